//--- design/ex1_pkg.sv
package ex1_pkg;

    localparam int XLEN          = 32;
    localparam int CNT_W         = 64;
    localparam int N_BYP_DEFAULT = 5;

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [6:0]       excp_code_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        // lu12i passes the shifted immediate straight through
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RF, SRC1_PC, SRC1_ZERO, SRC1_TID
    } src1_sel_e;

    // cntl/cnth pick a half of the stable counter
    typedef enum logic [1:0] {
        SRC2_RF, SRC2_IMM, SRC2_CNTL, SRC2_CNTH
    } src2_sel_e;

    typedef enum logic [3:0] {
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU,
        BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    // 22 bits, alu_op in the top nibble
    typedef struct packed {
        alu_op_e   alu_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      is_alu;
        logic      is_br;
        br_cond_e  br_cond;
        logic      is_mem;
        logic      mem_store;
        mem_size_e mem_size;
        logic      is_syscall;
        logic      is_break;
        logic      is_priv;
        logic      is_ertn;
    } uop_t;

    // ecode values of the loongarch exception table
    localparam excp_code_t EXC_SYS = 7'h0b;
    localparam excp_code_t EXC_BRK = 7'h0c;
    localparam excp_code_t EXC_IPE = 7'h0e;
    localparam excp_code_t EXC_ALE = 7'h09;

endpackage

//--- design/lane_ops_if.sv
interface lane_ops_if;

    // operands after bypass resolution
    ex1_pkg::xlen_t rj;
    ex1_pkg::xlen_t rk;
    ex1_pkg::xlen_t pc;
    ex1_pkg::xlen_t imm;
    ex1_pkg::uop_t  uop;

    modport lane (
        output rj,
        output rk,
        output pc,
        output imm,
        output uop
    );

    modport user (
        input rj,
        input rk,
        input pc,
        input imm,
        input uop
    );

endinterface

//--- design/operand_forward.sv
module operand_forward #(
    parameter int N_BYP = ex1_pkg::N_BYP_DEFAULT
) (
    input  ex1_pkg::reg_idx_t             rj_idx_i,
    input  ex1_pkg::reg_idx_t             rk_idx_i,
    input  ex1_pkg::xlen_t                rj_data_i,
    input  ex1_pkg::xlen_t                rk_data_i,
    input  ex1_pkg::reg_idx_t [N_BYP-1:0] byp_rd_i,
    input  ex1_pkg::xlen_t    [N_BYP-1:0] byp_data_i,
    input  logic              [N_BYP-1:0] byp_valid_i,
    output ex1_pkg::xlen_t                rj_o,
    output ex1_pkg::xlen_t                rk_o,
    output logic                          stall_o
);

    logic rj_miss;
    logic rk_miss;

    // returns {miss, data}; scan from the oldest slot so the youngest match lands last
    function automatic logic [ex1_pkg::XLEN:0] resolve(
        input ex1_pkg::reg_idx_t idx,
        input ex1_pkg::xlen_t    rf_val
    );
        logic [ex1_pkg::XLEN:0] res;
        res = {1'b0, rf_val};
        for (int i = N_BYP - 1; i >= 0; i--) begin
            if (idx != '0 && byp_rd_i[i] == idx) begin
                if (byp_valid_i[i]) begin
                    res = {1'b0, byp_data_i[i]};
                end else begin
                    // producer not done yet, keep rf value and flag it
                    res = {1'b1, rf_val};
                end
            end
        end
        return res;
    endfunction

    always_comb begin
        {rj_miss, rj_o} = resolve(rj_idx_i, rj_data_i);
        {rk_miss, rk_o} = resolve(rk_idx_i, rk_data_i);
    end

    assign stall_o = rj_miss | rk_miss;

endmodule

//--- design/ex_alu.sv
module ex_alu (
    input  ex1_pkg::alu_op_e op_i,
    input  ex1_pkg::xlen_t   a_i,
    input  ex1_pkg::xlen_t   b_i,
    output ex1_pkg::xlen_t   y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ex1_pkg::ALU_ADD:   y_o = a_i + b_i;
            ex1_pkg::ALU_SUB:   y_o = a_i - b_i;
            ex1_pkg::ALU_SLT:   y_o = {31'b0, ($signed(a_i) < $signed(b_i))};
            ex1_pkg::ALU_SLTU:  y_o = {31'b0, (a_i < b_i)};
            ex1_pkg::ALU_AND:   y_o = a_i & b_i;
            ex1_pkg::ALU_OR:    y_o = a_i | b_i;
            ex1_pkg::ALU_NOR:   y_o = ~(a_i | b_i);
            ex1_pkg::ALU_XOR:   y_o = a_i ^ b_i;
            ex1_pkg::ALU_SLL:   y_o = a_i << shamt;
            ex1_pkg::ALU_SRL:   y_o = a_i >> shamt;
            ex1_pkg::ALU_SRA:   y_o = ex1_pkg::xlen_t'($signed(a_i) >>> shamt);
            ex1_pkg::ALU_PASSB: y_o = b_i;
            default:            y_o = '0;
        endcase
    end

endmodule

//--- design/issue_lane.sv
module issue_lane #(
    parameter int N_BYP = ex1_pkg::N_BYP_DEFAULT
) (
    input  logic                          aclk,
    input  ex1_pkg::xlen_t                pc_i,
    input  ex1_pkg::uop_t                 uop_i,
    input  ex1_pkg::xlen_t                imm_i,
    input  ex1_pkg::reg_idx_t             rj_idx_i,
    input  ex1_pkg::reg_idx_t             rk_idx_i,
    input  ex1_pkg::xlen_t                rj_data_i,
    input  ex1_pkg::xlen_t                rk_data_i,
    input  ex1_pkg::xlen_t                tid_i,
    input  ex1_pkg::cnt_t                 counter_i,
    input  ex1_pkg::reg_idx_t [N_BYP-1:0] byp_rd_i,
    input  ex1_pkg::xlen_t    [N_BYP-1:0] byp_data_i,
    input  logic              [N_BYP-1:0] byp_valid_i,
    lane_ops_if.lane                      ops,
    output ex1_pkg::xlen_t                result_o,
    output logic                          result_valid_o,
    output logic                          stall_o
);

    ex1_pkg::xlen_t rj_fwd;
    ex1_pkg::xlen_t rk_fwd;
    ex1_pkg::xlen_t src_a;
    ex1_pkg::xlen_t src_b;
    ex1_pkg::xlen_t alu_y;
    logic           writes_rd;

    operand_forward #(
        .N_BYP (N_BYP)
    ) u_fwd (
        .rj_idx_i    (rj_idx_i),
        .rk_idx_i    (rk_idx_i),
        .rj_data_i   (rj_data_i),
        .rk_data_i   (rk_data_i),
        .byp_rd_i    (byp_rd_i),
        .byp_data_i  (byp_data_i),
        .byp_valid_i (byp_valid_i),
        .rj_o        (rj_fwd),
        .rk_o        (rk_fwd),
        .stall_o     (stall_o)
    );

    always_comb begin
        case (uop_i.src1_sel)
            ex1_pkg::SRC1_RF:   src_a = rj_fwd;
            ex1_pkg::SRC1_PC:   src_a = pc_i;
            ex1_pkg::SRC1_ZERO: src_a = '0;
            default:            src_a = tid_i;
        endcase
        case (uop_i.src2_sel)
            ex1_pkg::SRC2_RF:   src_b = rk_fwd;
            ex1_pkg::SRC2_IMM:  src_b = imm_i;
            ex1_pkg::SRC2_CNTL: src_b = counter_i[31:0];
            default:            src_b = counter_i[63:32];
        endcase
    end

    ex_alu u_alu (
        .op_i (uop_i.alu_op),
        .a_i  (src_a),
        .b_i  (src_b),
        .y_o  (alu_y)
    );

    // branches write the link address
    assign result_o = uop_i.is_br ? pc_i + 32'd4 : alu_y;

    // all-zero uop is a nop writing r0
    assign writes_rd      = uop_i.is_alu | uop_i.is_br | (uop_i == '0);
    assign result_valid_o = writes_rd & ~stall_o;

    assign ops.rj  = rj_fwd;
    assign ops.rk  = rk_fwd;
    assign ops.pc  = pc_i;
    assign ops.imm = imm_i;
    assign ops.uop = uop_i;

    // r0 reads the register file value and never waits on a producer
    r0_not_forwarded: assert property (@(posedge aclk)
        (rj_idx_i != '0 || rj_fwd == rj_data_i)
        && (rk_idx_i != '0 || rk_fwd == rk_data_i)
        && !(rj_idx_i == '0 && rk_idx_i == '0 && stall_o));

endmodule

//--- design/branch_resolve.sv
module branch_resolve (
    lane_ops_if.user       ops,
    input  logic           predict_taken_i,
    input  ex1_pkg::xlen_t predict_pc_i,
    output logic           dir_fail_o,
    output logic           addr_fail_o,
    output logic           taken_o,
    output ex1_pkg::xlen_t target_o
);

    logic           cond_met;
    ex1_pkg::xlen_t base;
    ex1_pkg::xlen_t target;

    always_comb begin
        case (ops.uop.br_cond)
            ex1_pkg::BR_BEQ:  cond_met = (ops.rj == ops.rk);
            ex1_pkg::BR_BNE:  cond_met = (ops.rj != ops.rk);
            ex1_pkg::BR_BLT:  cond_met = ($signed(ops.rj) < $signed(ops.rk));
            ex1_pkg::BR_BGE:  cond_met = ($signed(ops.rj) >= $signed(ops.rk));
            ex1_pkg::BR_BLTU: cond_met = (ops.rj < ops.rk);
            ex1_pkg::BR_BGEU: cond_met = (ops.rj >= ops.rk);
            ex1_pkg::BR_B,
            ex1_pkg::BR_BL,
            ex1_pkg::BR_JIRL: cond_met = 1'b1;
            default:          cond_met = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign base   = (ops.uop.br_cond == ex1_pkg::BR_JIRL) ? ops.rj : ops.pc;
    assign target = base + ops.imm;

    assign taken_o  = ops.uop.is_br & cond_met;
    assign target_o = ops.uop.is_br ? target : '0;

    assign dir_fail_o  = ops.uop.is_br & (cond_met != predict_taken_i);
    assign addr_fail_o = ops.uop.is_br & cond_met & predict_taken_i
                       & (target != predict_pc_i);

    // a branch uop carries one of the nine defined conditions
    cond_legal: assert final (
        !(ops.uop.is_br === 1'b1 && ops.uop.br_cond > ex1_pkg::BR_JIRL));

endmodule

//--- design/lsu_request.sv
module lsu_request (
    lane_ops_if.user       ops,
    input  logic           stall_i,
    output logic           rvalid_o,
    output logic           wvalid_o,
    output ex1_pkg::xlen_t addr_o,
    output logic [3:0]     wstrb_o,
    output ex1_pkg::xlen_t wdata_o,
    output logic           misalign_o
);

    logic       aligned;
    logic [3:0] strb_base;

    assign addr_o = ops.rj + ops.imm;

    always_comb begin
        case (ops.uop.mem_size)
            ex1_pkg::MEM_BYTE: begin
                aligned   = 1'b1;
                strb_base = 4'b0001;
                wdata_o   = {4{ops.rk[7:0]}};
            end
            ex1_pkg::MEM_HALF: begin
                aligned   = ~addr_o[0];
                strb_base = 4'b0011;
                wdata_o   = {2{ops.rk[15:0]}};
            end
            default: begin
                aligned   = (addr_o[1:0] == 2'b00);
                strb_base = 4'b1111;
                wdata_o   = ops.rk;
            end
        endcase
    end

    // loads carry no strobe
    assign wstrb_o = ops.uop.mem_store ? strb_base << addr_o[1:0] : 4'b0000;

    assign misalign_o = ops.uop.is_mem & ~aligned;

    assign rvalid_o = ops.uop.is_mem & ~ops.uop.mem_store & aligned & ~stall_i;
    assign wvalid_o = ops.uop.is_mem & ops.uop.mem_store & aligned & ~stall_i;

endmodule

//--- design/stage_control.sv
module stage_control (
    input  logic                aclk,
    input  logic                aresetn,
    input  ex1_pkg::uop_t       uop0_i,
    input  ex1_pkg::xlen_t      pc0_i,
    input  logic                plv_i,
    input  logic                excp_flag_i,
    input  ex1_pkg::excp_code_t excp_code_i,
    input  ex1_pkg::xlen_t      badv_i,
    input  logic                misalign_i,
    input  ex1_pkg::xlen_t      addr_i,
    input  logic                mispredict_i,
    output ex1_pkg::cnt_t       counter_o,
    output logic                excp_flag_o,
    output ex1_pkg::excp_code_t excp_code_o,
    output ex1_pkg::xlen_t      badv_o,
    output logic                flush_o
);

    ex1_pkg::cnt_t counter_q;

    // free running stable counter for rdcntv{l,h}
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            counter_q <= '0;
        end else begin
            counter_q <= counter_q + 1'b1;
        end
    end

    assign counter_o = counter_q;

    always_comb begin
        excp_flag_o = 1'b1;
        excp_code_o = '0;
        badv_o      = pc0_i;
        if (excp_flag_i) begin
            // earlier stage already faulted
            excp_code_o = excp_code_i;
            badv_o      = badv_i;
        end else if (uop0_i.is_syscall) begin
            excp_code_o = ex1_pkg::EXC_SYS;
        end else if (uop0_i.is_break) begin
            excp_code_o = ex1_pkg::EXC_BRK;
        end else if (uop0_i.is_priv && plv_i) begin
            // privileged op from user mode
            excp_code_o = ex1_pkg::EXC_IPE;
        end else if (misalign_i) begin
            excp_code_o = ex1_pkg::EXC_ALE;
            badv_o      = addr_i;
        end else begin
            excp_flag_o = 1'b0;
            badv_o      = '0;
        end
    end

    assign flush_o = mispredict_i | uop0_i.is_ertn;

    counter_monotonic: assert property (@(posedge aclk) disable iff (!aresetn)
        counter_q >= $past(counter_q));

endmodule

//--- design/ex1_stage.sv
module ex1_stage #(
    parameter int N_BYP = ex1_pkg::N_BYP_DEFAULT
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  ex1_pkg::xlen_t                pc0_i,
    input  ex1_pkg::xlen_t                pc1_i,
    input  ex1_pkg::uop_t                 uop0_i,
    input  ex1_pkg::uop_t                 uop1_i,
    input  ex1_pkg::xlen_t                imm0_i,
    input  ex1_pkg::xlen_t                imm1_i,
    input  ex1_pkg::reg_idx_t             rj0_idx_i,
    input  ex1_pkg::reg_idx_t             rk0_idx_i,
    input  ex1_pkg::reg_idx_t             rj1_idx_i,
    input  ex1_pkg::reg_idx_t             rk1_idx_i,
    input  ex1_pkg::xlen_t                rj0_data_i,
    input  ex1_pkg::xlen_t                rk0_data_i,
    input  ex1_pkg::xlen_t                rj1_data_i,
    input  ex1_pkg::xlen_t                rk1_data_i,
    input  ex1_pkg::xlen_t                tid_i,
    input  ex1_pkg::reg_idx_t [N_BYP-1:0] byp_rd_i,
    input  ex1_pkg::xlen_t    [N_BYP-1:0] byp_data_i,
    input  logic              [N_BYP-1:0] byp_valid_i,
    input  logic                          predict_taken_i,
    input  ex1_pkg::xlen_t                predict_pc_i,
    input  logic                          plv_i,
    input  logic                          excp_flag_i,
    input  ex1_pkg::excp_code_t           excp_code_i,
    input  ex1_pkg::xlen_t                badv_i,
    output ex1_pkg::xlen_t                alu_result0_o,
    output ex1_pkg::xlen_t                alu_result1_o,
    output logic                          alu_result0_valid_o,
    output logic                          alu_result1_valid_o,
    output logic                          forward_stall_o,
    output logic                          flush_o,
    output logic                          predict_dir_fail_o,
    output logic                          predict_addr_fail_o,
    output logic                          fact_taken_o,
    output ex1_pkg::xlen_t                fact_tpc_o,
    output logic                          dcache_rvalid_o,
    output logic                          dcache_wvalid_o,
    output ex1_pkg::xlen_t                dcache_addr_o,
    output logic [3:0]                    dcache_wstrb_o,
    output ex1_pkg::xlen_t                dcache_wdata_o,
    output logic                          excp_flag_o,
    output ex1_pkg::excp_code_t           excp_code_o,
    output ex1_pkg::xlen_t                badv_o,
    output ex1_pkg::cnt_t                 stable_counter_o
);

    lane_ops_if lane0_ops ();
    lane_ops_if lane1_ops ();

    logic stall0;
    logic stall1;
    logic misalign;
    logic mispredict;

    assign forward_stall_o = stall0 | stall1;
    assign mispredict      = predict_dir_fail_o | predict_addr_fail_o;

    issue_lane #(
        .N_BYP (N_BYP)
    ) u_lane0 (
        .aclk           (aclk),
        .pc_i           (pc0_i),
        .uop_i          (uop0_i),
        .imm_i          (imm0_i),
        .rj_idx_i       (rj0_idx_i),
        .rk_idx_i       (rk0_idx_i),
        .rj_data_i      (rj0_data_i),
        .rk_data_i      (rk0_data_i),
        .tid_i          (tid_i),
        .counter_i      (stable_counter_o),
        .byp_rd_i       (byp_rd_i),
        .byp_data_i     (byp_data_i),
        .byp_valid_i    (byp_valid_i),
        .ops            (lane0_ops.lane),
        .result_o       (alu_result0_o),
        .result_valid_o (alu_result0_valid_o),
        .stall_o        (stall0)
    );

    // lane 1 has no branch or memory port
    issue_lane #(
        .N_BYP (N_BYP)
    ) u_lane1 (
        .aclk           (aclk),
        .pc_i           (pc1_i),
        .uop_i          (uop1_i),
        .imm_i          (imm1_i),
        .rj_idx_i       (rj1_idx_i),
        .rk_idx_i       (rk1_idx_i),
        .rj_data_i      (rj1_data_i),
        .rk_data_i      (rk1_data_i),
        .tid_i          (tid_i),
        .counter_i      (stable_counter_o),
        .byp_rd_i       (byp_rd_i),
        .byp_data_i     (byp_data_i),
        .byp_valid_i    (byp_valid_i),
        .ops            (lane1_ops.lane),
        .result_o       (alu_result1_o),
        .result_valid_o (alu_result1_valid_o),
        .stall_o        (stall1)
    );

    branch_resolve u_branch (
        .ops             (lane0_ops.user),
        .predict_taken_i (predict_taken_i),
        .predict_pc_i    (predict_pc_i),
        .dir_fail_o      (predict_dir_fail_o),
        .addr_fail_o     (predict_addr_fail_o),
        .taken_o         (fact_taken_o),
        .target_o        (fact_tpc_o)
    );

    lsu_request u_lsu (
        .ops        (lane0_ops.user),
        .stall_i    (forward_stall_o),
        .rvalid_o   (dcache_rvalid_o),
        .wvalid_o   (dcache_wvalid_o),
        .addr_o     (dcache_addr_o),
        .wstrb_o    (dcache_wstrb_o),
        .wdata_o    (dcache_wdata_o),
        .misalign_o (misalign)
    );

    stage_control u_ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .uop0_i       (uop0_i),
        .pc0_i        (pc0_i),
        .plv_i        (plv_i),
        .excp_flag_i  (excp_flag_i),
        .excp_code_i  (excp_code_i),
        .badv_i       (badv_i),
        .misalign_i   (misalign),
        .addr_i       (dcache_addr_o),
        .mispredict_i (mispredict),
        .counter_o    (stable_counter_o),
        .excp_flag_o  (excp_flag_o),
        .excp_code_o  (excp_code_o),
        .badv_o       (badv_o),
        .flush_o      (flush_o)
    );

endmodule

//--- dv/ex1_tb.sv
module ex1_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BYP          = 5;
    localparam int N_CYCLES       = 3000;
    // reset, one idle cycle and some slack on top of the random run
    localparam int TIMEOUT_CYCLES = N_CYCLES + 200;

    logic                          aclk;
    logic                          aresetn;
    ex1_pkg::xlen_t                pc0, pc1, imm0, imm1, tid;
    ex1_pkg::uop_t                 uop0, uop1;
    ex1_pkg::reg_idx_t             rj0_idx, rk0_idx, rj1_idx, rk1_idx;
    ex1_pkg::xlen_t                rj0_data, rk0_data, rj1_data, rk1_data;
    ex1_pkg::reg_idx_t [N_BYP-1:0] byp_rd;
    ex1_pkg::xlen_t    [N_BYP-1:0] byp_data;
    logic              [N_BYP-1:0] byp_valid;
    logic                          predict_taken, plv, excp_flag_in;
    ex1_pkg::xlen_t                predict_pc, badv_in;
    ex1_pkg::excp_code_t           excp_code_in;

    ex1_pkg::xlen_t      alu_result0, alu_result1, fact_tpc, dcache_addr, dcache_wdata, badv;
    logic                alu_result0_valid, alu_result1_valid, forward_stall, flush;
    logic                predict_dir_fail, predict_addr_fail, fact_taken;
    logic                dcache_rvalid, dcache_wvalid, excp_flag;
    logic [3:0]          dcache_wstrb;
    ex1_pkg::excp_code_t excp_code;
    ex1_pkg::cnt_t       stable_counter;

    ex1_pkg::cnt_t exp_cnt;
    int            cycle_cnt;
    int            mismatches;
    int            other_errors;

    ex1_stage #(
        .N_BYP (N_BYP)
    ) UUT (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .pc0_i               (pc0),
        .pc1_i               (pc1),
        .uop0_i              (uop0),
        .uop1_i              (uop1),
        .imm0_i              (imm0),
        .imm1_i              (imm1),
        .rj0_idx_i           (rj0_idx),
        .rk0_idx_i           (rk0_idx),
        .rj1_idx_i           (rj1_idx),
        .rk1_idx_i           (rk1_idx),
        .rj0_data_i          (rj0_data),
        .rk0_data_i          (rk0_data),
        .rj1_data_i          (rj1_data),
        .rk1_data_i          (rk1_data),
        .tid_i               (tid),
        .byp_rd_i            (byp_rd),
        .byp_data_i          (byp_data),
        .byp_valid_i         (byp_valid),
        .predict_taken_i     (predict_taken),
        .predict_pc_i        (predict_pc),
        .plv_i               (plv),
        .excp_flag_i         (excp_flag_in),
        .excp_code_i         (excp_code_in),
        .badv_i              (badv_in),
        .alu_result0_o       (alu_result0),
        .alu_result1_o       (alu_result1),
        .alu_result0_valid_o (alu_result0_valid),
        .alu_result1_valid_o (alu_result1_valid),
        .forward_stall_o     (forward_stall),
        .flush_o             (flush),
        .predict_dir_fail_o  (predict_dir_fail),
        .predict_addr_fail_o (predict_addr_fail),
        .fact_taken_o        (fact_taken),
        .fact_tpc_o          (fact_tpc),
        .dcache_rvalid_o     (dcache_rvalid),
        .dcache_wvalid_o     (dcache_wvalid),
        .dcache_addr_o       (dcache_addr),
        .dcache_wstrb_o      (dcache_wstrb),
        .dcache_wdata_o      (dcache_wdata),
        .excp_flag_o         (excp_flag),
        .excp_code_o         (excp_code),
        .badv_o              (badv),
        .stable_counter_o    (stable_counter)
    );

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    // counter model: edges seen since reset release
    always @(posedge aclk) begin
        if (!aresetn) begin
            exp_cnt <= '0;
        end else begin
            exp_cnt <= exp_cnt + 1;
        end
    end

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            other_errors++;
            report_counts();
            $display("tests failed");
            $finish;
        end
    end

    task automatic report_counts();
        $display("error counts: %0d mismatches, %0d other errors", mismatches, other_errors);
    endtask

    task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
        assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    // youngest slot first, first match decides; returns {miss, data}
    function automatic logic [32:0] fwd_model(input ex1_pkg::reg_idx_t idx,
                                              input ex1_pkg::xlen_t rf_val);
        int s;
        for (s = 0; s < N_BYP; s++) begin
            if (idx != 5'd0 && byp_rd[s] == idx) begin
                return byp_valid[s] ? {1'b0, byp_data[s]} : {1'b1, rf_val};
            end
        end
        return {1'b0, rf_val};
    endfunction

    function automatic ex1_pkg::xlen_t alu_model(input ex1_pkg::alu_op_e op,
                                                 input ex1_pkg::xlen_t a,
                                                 input ex1_pkg::xlen_t b);
        case (op)
            ex1_pkg::ALU_ADD:   return a + b;
            ex1_pkg::ALU_SUB:   return a - b;
            ex1_pkg::ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ex1_pkg::ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ex1_pkg::ALU_AND:   return a & b;
            ex1_pkg::ALU_OR:    return a | b;
            ex1_pkg::ALU_NOR:   return ~(a | b);
            ex1_pkg::ALU_XOR:   return a ^ b;
            ex1_pkg::ALU_SLL:   return a << b[4:0];
            ex1_pkg::ALU_SRL:   return a >> b[4:0];
            ex1_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
            ex1_pkg::ALU_PASSB: return b;
            default:            return '0;
        endcase
    endfunction

    task automatic lane_model(input ex1_pkg::uop_t u, input ex1_pkg::xlen_t pc,
                              input ex1_pkg::xlen_t imm, input ex1_pkg::reg_idx_t rji,
                              input ex1_pkg::reg_idx_t rki, input ex1_pkg::xlen_t rjd,
                              input ex1_pkg::xlen_t rkd, output ex1_pkg::xlen_t rj_f,
                              output ex1_pkg::xlen_t rk_f, output ex1_pkg::xlen_t res,
                              output logic valid, output logic stall);
        logic [32:0]    fj;
        logic [32:0]    fk;
        ex1_pkg::xlen_t a;
        ex1_pkg::xlen_t b;
        fj    = fwd_model(rji, rjd);
        fk    = fwd_model(rki, rkd);
        rj_f  = fj[31:0];
        rk_f  = fk[31:0];
        stall = fj[32] | fk[32];
        case (u.src1_sel)
            ex1_pkg::SRC1_RF:   a = rj_f;
            ex1_pkg::SRC1_PC:   a = pc;
            ex1_pkg::SRC1_ZERO: a = '0;
            default:            a = tid;
        endcase
        case (u.src2_sel)
            ex1_pkg::SRC2_RF:   b = rk_f;
            ex1_pkg::SRC2_IMM:  b = imm;
            ex1_pkg::SRC2_CNTL: b = exp_cnt[31:0];
            default:            b = exp_cnt[63:32];
        endcase
        res   = u.is_br ? pc + 32'd4 : alu_model(u.alu_op, a, b);
        valid = (u.is_alu | u.is_br | (u == '0)) & ~stall;
    endtask

    task automatic check_outputs();
        ex1_pkg::xlen_t      rj0f, rk0f, rj1f, rk1f, res0, res1, tgt, addr, wdata, e_badv;
        logic                v0, v1, st0, st1, stall, cond, dirf, addrf, aligned, e_flag;
        logic [3:0]          strb;
        ex1_pkg::excp_code_t e_code;
        lane_model(uop0, pc0, imm0, rj0_idx, rk0_idx, rj0_data, rk0_data,
                   rj0f, rk0f, res0, v0, st0);
        lane_model(uop1, pc1, imm1, rj1_idx, rk1_idx, rj1_data, rk1_data,
                   rj1f, rk1f, res1, v1, st1);
        stall = st0 | st1;
        case (uop0.br_cond)
            ex1_pkg::BR_BEQ:  cond = (rj0f == rk0f);
            ex1_pkg::BR_BNE:  cond = (rj0f != rk0f);
            ex1_pkg::BR_BLT:  cond = ($signed(rj0f) < $signed(rk0f));
            ex1_pkg::BR_BGE:  cond = ($signed(rj0f) >= $signed(rk0f));
            ex1_pkg::BR_BLTU: cond = (rj0f < rk0f);
            ex1_pkg::BR_BGEU: cond = (rj0f >= rk0f);
            ex1_pkg::BR_B,
            ex1_pkg::BR_BL,
            ex1_pkg::BR_JIRL: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
        tgt   = ((uop0.br_cond == ex1_pkg::BR_JIRL) ? rj0f : pc0) + imm0;
        dirf  = uop0.is_br & (cond != predict_taken);
        addrf = uop0.is_br & cond & predict_taken & (tgt != predict_pc);
        addr  = rj0f + imm0;
        case (uop0.mem_size)
            ex1_pkg::MEM_BYTE: begin
                aligned = 1'b1;
                strb    = 4'b0001;
                wdata   = {4{rk0f[7:0]}};
            end
            ex1_pkg::MEM_HALF: begin
                aligned = ~addr[0];
                strb    = 4'b0011;
                wdata   = {2{rk0f[15:0]}};
            end
            default: begin
                aligned = (addr[1:0] == 2'b00);
                strb    = 4'b1111;
                wdata   = rk0f;
            end
        endcase
        strb   = uop0.mem_store ? strb << addr[1:0] : 4'b0000;
        e_flag = 1'b1;
        e_badv = pc0;
        if (excp_flag_in) begin
            e_code = excp_code_in;
            e_badv = badv_in;
        end else if (uop0.is_syscall) begin
            e_code = ex1_pkg::EXC_SYS;
        end else if (uop0.is_break) begin
            e_code = ex1_pkg::EXC_BRK;
        end else if (uop0.is_priv && plv) begin
            e_code = ex1_pkg::EXC_IPE;
        end else if (uop0.is_mem && !aligned) begin
            e_code = ex1_pkg::EXC_ALE;
            e_badv = addr;
        end else begin
            e_flag = 1'b0;
            e_code = '0;
            e_badv = '0;
        end
        check_val("alu_result0_o", alu_result0, res0);
        check_val("alu_result1_o", alu_result1, res1);
        check_val("alu_result0_valid_o", alu_result0_valid, v0);
        check_val("alu_result1_valid_o", alu_result1_valid, v1);
        check_val("forward_stall_o", forward_stall, stall);
        check_val("fact_taken_o", fact_taken, uop0.is_br & cond);
        check_val("fact_tpc_o", fact_tpc, uop0.is_br ? tgt : 32'd0);
        check_val("predict_dir_fail_o", predict_dir_fail, dirf);
        check_val("predict_addr_fail_o", predict_addr_fail, addrf);
        check_val("flush_o", flush, dirf | addrf | uop0.is_ertn);
        check_val("dcache_addr_o", dcache_addr, addr);
        check_val("dcache_wstrb_o", dcache_wstrb, strb);
        check_val("dcache_wdata_o", dcache_wdata, wdata);
        check_val("dcache_rvalid_o", dcache_rvalid,
                  uop0.is_mem & ~uop0.mem_store & aligned & ~stall);
        check_val("dcache_wvalid_o", dcache_wvalid,
                  uop0.is_mem & uop0.mem_store & aligned & ~stall);
        check_val("excp_flag_o", excp_flag, e_flag);
        check_val("excp_code_o", excp_code, e_code);
        check_val("badv_o", badv, e_badv);
        check_val("stable_counter_o", stable_counter, exp_cnt);
    endtask

    // zero uops: nothing in the control path may be active
    task automatic check_idle();
        check_val("stable_counter_o", stable_counter, 64'h0);
        check_val("flush_o", flush, 1'b0);
        check_val("predict_dir_fail_o", predict_dir_fail, 1'b0);
        check_val("predict_addr_fail_o", predict_addr_fail, 1'b0);
        check_val("dcache_rvalid_o", dcache_rvalid, 1'b0);
        check_val("dcache_wvalid_o", dcache_wvalid, 1'b0);
        check_val("excp_flag_o", excp_flag, 1'b0);
    endtask

    function automatic ex1_pkg::uop_t rand_uop();
        ex1_pkg::uop_t u;
        u = '0;
        if ($urandom % 16 == 0) begin
            return u;
        end
        u.alu_op     = ex1_pkg::alu_op_e'($urandom % 12);
        u.src1_sel   = ex1_pkg::src1_sel_e'($urandom % 4);
        u.src2_sel   = ex1_pkg::src2_sel_e'($urandom % 4);
        u.is_alu     = $urandom % 2;
        u.is_br      = ($urandom % 4) == 0;
        u.br_cond    = ex1_pkg::br_cond_e'($urandom % 9);
        u.is_mem     = ($urandom % 3) == 0;
        u.mem_store  = ($urandom % 2) && u.is_mem;
        u.mem_size   = ex1_pkg::mem_size_e'($urandom % 3);
        u.is_syscall = ($urandom % 16) == 0;
        u.is_break   = ($urandom % 16) == 0;
        u.is_priv    = ($urandom % 8) == 0;
        u.is_ertn    = ($urandom % 16) == 0;
        return u;
    endfunction

    function automatic ex1_pkg::xlen_t rand_imm();
        logic [11:0] r;
        r = $urandom;
        return {{20{r[11]}}, r};
    endfunction

    task automatic drive_random();
        int s;
        // indices 0..7 keep bypass hits frequent
        for (s = 0; s < N_BYP; s++) begin
            byp_rd[s]    = $urandom % 8;
            byp_data[s]  = $urandom;
            byp_valid[s] = ($urandom % 10) != 0;
        end
        rj0_idx       = $urandom % 8;
        rk0_idx       = $urandom % 8;
        rj1_idx       = $urandom % 8;
        rk1_idx       = $urandom % 8;
        rj0_data      = $urandom;
        rk0_data      = $urandom;
        rj1_data      = $urandom;
        rk1_data      = $urandom;
        pc0           = $urandom & 32'hffff_fffc;
        pc1           = pc0 + 32'd4;
        imm0          = rand_imm();
        imm1          = rand_imm();
        tid           = $urandom;
        uop0          = rand_uop();
        uop1          = rand_uop();
        predict_taken = $urandom % 2;
        predict_pc    = ($urandom % 2) ? pc0 + imm0 : $urandom;
        plv           = $urandom % 2;
        excp_flag_in  = ($urandom % 8) == 0;
        excp_code_in  = $urandom;
        badv_in       = $urandom;
    endtask

    initial begin
        int n;
        void'($urandom(77676));
        cycle_cnt     = 0;
        mismatches    = 0;
        other_errors  = 0;
        aresetn       = 1'b0;
        pc0           = '0;
        pc1           = '0;
        imm0          = '0;
        imm1          = '0;
        tid           = '0;
        uop0          = '0;
        uop1          = '0;
        rj0_idx       = '0;
        rk0_idx       = '0;
        rj1_idx       = '0;
        rk1_idx       = '0;
        rj0_data      = '0;
        rk0_data      = '0;
        rj1_data      = '0;
        rk1_data      = '0;
        byp_rd        = '0;
        byp_data      = '0;
        byp_valid     = '0;
        predict_taken = 1'b0;
        predict_pc    = '0;
        plv           = 1'b0;
        excp_flag_in  = 1'b0;
        excp_code_in  = '0;
        badv_in       = '0;

        @(posedge aclk);
        #3 check_idle();
        @(posedge aclk);
        #1 aresetn = 1'b1;
        // first cycle out of reset still reads zero
        #2 check_idle();

        for (n = 0; n < N_CYCLES; n++) begin
            @(posedge aclk);
            #1 drive_random();
            #2 check_outputs();
        end

        report_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- ex1_stage.f
design/ex1_pkg.sv
design/lane_ops_if.sv
design/operand_forward.sv
design/ex_alu.sv
design/issue_lane.sv
design/branch_resolve.sv
design/lsu_request.sv
design/stage_control.sv
design/ex1_stage.sv
dv/ex1_tb.sv
